/* compile.f */
logic/frontend_pkg.sv
logic/pc_gen.sv
logic/ifetch.sv
logic/imem.sv
logic/iqueue.sv
logic/frontend_top.sv
testbench/frontend_props.sv
testbench/tb_frontend.sv

/* logic/frontend_pkg.sv */
// shared widths, bus structs and fetch-word types for the fetch front end; compile it first.
`default_nettype none

package frontend_pkg;

	localparam int XLEN = 64; // address and fetch-word width.
	localparam int INSTR_W = 32; // one instruction.
	localparam logic [XLEN-1:0] BOOT_PC = '0; // first fetch after reset.

	localparam int MEM_WORDS = 64; // imem depth in double-words.
	localparam int MEM_AW = 6; // word index, taken from addr[8:3].

	localparam int IQ_DEPTH = 4; // fetch entries in the queue.
	localparam int IQ_PW = 2; // queue pointer width.
	localparam int IQ_CW = 3; // queue count width, holds 0..IQ_DEPTH.
	// keep one slot free for the word still in flight on the bus.
	localparam logic [IQ_CW-1:0] IQ_FILL_MAX = IQ_CW'(IQ_DEPTH - 2);

	// fetch request toward imem.
	typedef struct packed {
		logic valid;
		logic kill; // drops the answer still pending.
		logic [XLEN-1:0] addr; // always double-word aligned.
	} bus_req_t;

	// read answer from imem.
	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] data;
	} bus_rsp_t;

	// one fetched double-word, seen whole or as two instructions.
	typedef union packed {
		logic [XLEN-1:0] dword;
		struct packed {
			logic [INSTR_W-1:0] hi; // addr + 4.
			logic [INSTR_W-1:0] lo; // lower address.
		} half;
	} fetch_word_u;

	typedef struct packed {
		logic [XLEN-1:0] addr; // unaligned fetch address, bit 2 picks start half.
		fetch_word_u word;
	} iq_entry_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [INSTR_W-1:0] instr;
	} dec_out_t;

endpackage

`default_nettype wire

/* logic/frontend_top.sv */
// fetch front end top; joins pc_gen, ifetch, imem and iqueue and hands instructions to decode.
`default_nettype none
`timescale 1ns/1ns

module frontend_top (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic mem_we, // program load port.
	input wire logic [frontend_pkg::MEM_AW-1:0] mem_waddr,
	input wire logic [frontend_pkg::XLEN-1:0] mem_wdata,
	input wire logic flush, // one-cycle pulse.
	input wire logic [frontend_pkg::XLEN-1:0] redirect_pc, // valid with flush.
	input wire logic dec_ready,
	output logic dec_valid,
	output frontend_pkg::dec_out_t dec_out
);

	logic [frontend_pkg::XLEN-1:0] fetch_pc;
	logic fetch_ready;
	frontend_pkg::bus_req_t bus_req;
	frontend_pkg::bus_rsp_t bus_rsp;
	logic req_ready;
	frontend_pkg::iq_entry_t iq_in;
	logic iq_valid;
	logic iq_ready;

	pc_gen u_pc_gen (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.fetch_ready(fetch_ready),
		.redirect_pc(redirect_pc),
		.fetch_pc(fetch_pc)
	);

	// bus master side.
	ifetch u_ifetch (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.req_ready(req_ready),
		.iq_ready(iq_ready),
		.fetch_pc(fetch_pc),
		.bus_rsp(bus_rsp),
		.bus_req(bus_req),
		.fetch_ready(fetch_ready),
		.iq_valid(iq_valid),
		.iq_in(iq_in)
	);

	imem u_imem (
		.CLK(CLK),
		.rst_n(rst_n),
		.mem_we(mem_we),
		.mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata),
		.bus_req(bus_req),
		.req_ready(req_ready),
		.bus_rsp(bus_rsp)
	);

	iqueue u_iqueue (
		.CLK(CLK),
		.rst_n(rst_n),
		.flush(flush),
		.iq_valid(iq_valid),
		.dec_ready(dec_ready),
		.iq_in(iq_in),
		.iq_ready(iq_ready),
		.dec_valid(dec_valid),
		.dec_out(dec_out)
	);

endmodule

`default_nettype wire

/* logic/ifetch.sv */
// fetch unit; issues one aligned read per request on the imem bus and captures the answer for the queue.
`default_nettype none
`timescale 1ns/1ns

module ifetch (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic flush,
	input wire logic req_ready, // imem not busy.
	input wire logic iq_ready, // queue has room for one more word.
	input wire logic [frontend_pkg::XLEN-1:0] fetch_pc,
	input wire frontend_pkg::bus_rsp_t bus_rsp,
	output frontend_pkg::bus_req_t bus_req,
	output logic fetch_ready, // advances pc_gen.
	output logic iq_valid,
	output frontend_pkg::iq_entry_t iq_in
);

	logic bus_ready; // req_ready, one cycle late.
	logic boot; // set after reset and flush, lets the first fetch skip the queue check.
	logic issue;
	logic [frontend_pkg::XLEN-1:0] pending_addr; // address of the read in flight.

	assign issue = bus_ready & (iq_ready | boot) & ~flush;
	assign fetch_ready = issue;

	// kill rides along with every cycle of flush.
	assign bus_req = '{valid: issue, kill: flush,
		addr: {fetch_pc[frontend_pkg::XLEN-1:3], 3'b000}};

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			bus_ready <= 1'b0; // no request in the first cycle out of reset.
			boot <= 1'b1;
			iq_valid <= 1'b0;
		end else begin
			bus_ready <= req_ready;
			if (flush) boot <= 1'b1;
			else if (issue) boot <= 1'b0;
			// a fresh answer outranks the clear from a transfer.
			if (bus_rsp.valid & ~flush) iq_valid <= 1'b1;
			else if (iq_ready | flush) iq_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (issue) pending_addr <= fetch_pc; // unaligned, bit 2 travels on.
		if (bus_rsp.valid) begin
			iq_in.addr <= pending_addr;
			iq_in.word.dword <= bus_rsp.data;
		end
	end

endmodule

`default_nettype wire

/* logic/imem.sv */
// instruction memory acting as bus slave; loaded through the write port, answers each read one cycle later.
`default_nettype none
`timescale 1ns/1ns

module imem (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic mem_we, // load strobe, one double-word per cycle.
	input wire logic [frontend_pkg::MEM_AW-1:0] mem_waddr,
	input wire logic [frontend_pkg::XLEN-1:0] mem_wdata,
	input wire frontend_pkg::bus_req_t bus_req,
	output logic req_ready,
	output frontend_pkg::bus_rsp_t bus_rsp
);

	logic [frontend_pkg::XLEN-1:0] mem [frontend_pkg::MEM_WORDS];
	logic [frontend_pkg::MEM_AW-1:0] ridx;
	logic [frontend_pkg::XLEN-1:0] rdata; // read word held for the answer.
	logic pend; // an accepted read answers this cycle.

	// double-word index, higher bits ignored so fetch wraps around the array.
	assign ridx = bus_req.addr[frontend_pkg::MEM_AW+2:3];

	assign req_ready = ~pend; // busy while the answer is out.

	// a kill in the answer cycle drops it.
	assign bus_rsp = '{valid: pend & ~bus_req.kill, data: rdata};

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pend <= 1'b0;
		end else begin
			pend <= bus_req.valid; // every valid request is taken.
		end
	end

	always_ff @(posedge CLK) begin
		if (mem_we) begin
			mem[mem_waddr] <= mem_wdata; // visible to reads from the next cycle.
		end
		if (bus_req.valid) begin
			rdata <= mem[ridx];
		end
	end

endmodule

`default_nettype wire

/* logic/iqueue.sv */
// fetch queue; buffers double-words and hands them to decode one 32-bit instruction at a time.
`default_nettype none
`timescale 1ns/1ns

module iqueue (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic flush, // empties the queue.
	input wire logic iq_valid,
	input wire logic dec_ready,
	input wire frontend_pkg::iq_entry_t iq_in,
	output logic iq_ready,
	output logic dec_valid,
	output frontend_pkg::dec_out_t dec_out
);

	frontend_pkg::iq_entry_t fifo [frontend_pkg::IQ_DEPTH]; // payload only.
	frontend_pkg::iq_entry_t head;
	logic [frontend_pkg::IQ_PW-1:0] wr_ptr;
	logic [frontend_pkg::IQ_PW-1:0] rd_ptr;
	logic [frontend_pkg::IQ_CW-1:0] count;
	logic half_q; // low half of the head already sent.
	logic hi; // head half on offer now.
	logic push;
	logic take; // one instruction to decode.
	logic pop; // head fully consumed.

	assign head = fifo[rd_ptr];

	// an entry fetched at addr bit 2 set starts on its high half.
	assign hi = half_q | head.addr[2];

	assign dec_valid = (count != '0);
	assign iq_ready = (count <= frontend_pkg::IQ_FILL_MAX);

	assign push = iq_valid & iq_ready;
	assign take = dec_valid & dec_ready;
	assign pop = take & hi; // leave after the high half.

	// pc is the aligned address, plus 4 for the high half.
	assign dec_out = '{pc: {head.addr[frontend_pkg::XLEN-1:3], hi, 2'b00},
		instr: hi ? head.word.half.hi : head.word.half.lo};

	always_ff @(posedge CLK) begin
		if (push) fifo[wr_ptr] <= iq_in;
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			half_q <= 1'b0;
		end else if (flush) begin
			wr_ptr <= '0; // a word landing in the flush cycle is dropped too.
			rd_ptr <= '0;
			count <= '0;
			half_q <= 1'b0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;

			if (pop) half_q <= 1'b0; // next head picks its own start half.
			else if (take) half_q <= 1'b1;

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // none, or one in and one out.
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/pc_gen.sv */
// fetch address register; steps one aligned double-word per issued request, loads redirects.
`default_nettype none
`timescale 1ns/1ns

module pc_gen (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic flush, // one-cycle redirect strobe.
	input wire logic fetch_ready, // high in each cycle a request issues.
	input wire logic [frontend_pkg::XLEN-1:0] redirect_pc,
	output logic [frontend_pkg::XLEN-1:0] fetch_pc
);

	logic [frontend_pkg::XLEN-1:0] next_seq; // next aligned double-word.

	// drop the byte offset, step one double-word.
	// an unaligned redirect lands on the following aligned word here.
	assign next_seq = {fetch_pc[frontend_pkg::XLEN-1:3] + 1'b1, 3'b000};

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			fetch_pc <= frontend_pkg::BOOT_PC;
		end else if (flush) begin
			fetch_pc <= redirect_pc; // flush wins, kept unaligned for start-half select.
		end else if (fetch_ready) begin
			fetch_pc <= next_seq;
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build and run the front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_frontend -Mdir obj_dir -f compile.f; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_frontend 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with no errors" <<< "$out"; then
	exit 0
fi
exit 1

/* testbench/frontend_props.sv */
// concurrent checks on the fetch bus and decode side, bound into the front end top.
`timescale 1ns/1ns
`default_nettype none

module frontend_props (
	input wire logic CLK,
	input wire logic rst_n,
	input wire logic flush,
	input wire logic [frontend_pkg::XLEN-1:0] redirect_pc,
	input wire frontend_pkg::bus_req_t bus_req,
	input wire logic dec_ready,
	input wire logic dec_valid,
	input wire frontend_pkg::dec_out_t dec_out
);

	// a stalled offer holds still until decode takes it.
	dec_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		dec_valid && !dec_ready && !flush |=> $stable(dec_out))
		else $error("dec_out changed while decode was stalled");

	// a read right after a redirect goes to its aligned double-word.
	req_after_flush: assert property (@(posedge CLK) disable iff (!rst_n)
		flush ##1 bus_req.valid |->
			bus_req.addr == {$past(redirect_pc[frontend_pkg::XLEN-1:3], 1), 3'b000})
		else $error("first request after flush is not at the redirect address");

	dec_idle_after_flush: assert property (@(posedge CLK) disable iff (!rst_n)
		flush |=> !dec_valid)
		else $error("dec_valid high right after flush"); // queue is empty then.

endmodule

bind frontend_top frontend_props u_props (
	.CLK(CLK),
	.rst_n(rst_n),
	.flush(flush),
	.redirect_pc(redirect_pc),
	.bus_req(bus_req),
	.dec_ready(dec_ready),
	.dec_valid(dec_valid),
	.dec_out(dec_out)
);

`default_nettype wire

/* testbench/tb_frontend.sv */
// testbench for the fetch front end; loads a program image, runs a table of flush and stall rows.
`timescale 1ns/1ns
`default_nettype none

module tb_frontend;

	typedef enum int {BOOT_ONLY, ONE_FLUSH, TWO_FLUSH} row_kind_e;

	// one stimulus row with the stream it expects.
	typedef struct packed {
		row_kind_e kind;
		logic [frontend_pkg::XLEN-1:0] decoy_pc; // first target of a double flush.
		logic [frontend_pkg::XLEN-1:0] start_pc; // first pc decode must see.
		int reload_idx; // word rewritten before the row, -1 for none.
		int count; // instructions to check.
		int stall_pct; // chance of dec_ready low, in percent.
	} row_t;

	logic CLK;
	logic rst_n;
	logic mem_we;
	logic [frontend_pkg::MEM_AW-1:0] mem_waddr;
	logic [frontend_pkg::XLEN-1:0] mem_wdata;
	logic flush;
	logic [frontend_pkg::XLEN-1:0] redirect_pc;
	logic dec_ready;
	logic dec_valid;
	frontend_pkg::dec_out_t dec_out;

	logic [frontend_pkg::XLEN-1:0] image [frontend_pkg::MEM_WORDS]; // expected memory contents.
	row_t rows [$];
	string names [$];
	int mismatches;
	int timeouts;

	frontend_top DUT (
		.CLK(CLK),
		.rst_n(rst_n),
		.mem_we(mem_we),
		.mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata),
		.flush(flush),
		.redirect_pc(redirect_pc),
		.dec_ready(dec_ready),
		.dec_valid(dec_valid),
		.dec_out(dec_out)
	);

	always #10 CLK = ~CLK; // 20 ns period.

	// each instruction slot carries its own byte address twice.
	function automatic logic [31:0] pattern(input logic [8:0] byte_addr);
		return {7'h2a, byte_addr, 7'h15, byte_addr};
	endfunction

	// memory wraps every MEM_WORDS double-words, bit 2 picks the half.
	function automatic logic [31:0] expect_instr(input logic [frontend_pkg::XLEN-1:0] pc);
		logic [frontend_pkg::XLEN-1:0] w;
		w = image[pc[frontend_pkg::MEM_AW+2:3]];
		return pc[2] ? w[63:32] : w[31:0];
	endfunction

	task automatic add_row(input string name, input row_kind_e kind,
		input logic [frontend_pkg::XLEN-1:0] decoy, input logic [frontend_pkg::XLEN-1:0] start,
		input int reload_idx, input int count, input int stall_pct);
		row_t r;
		r = '{kind: kind, decoy_pc: decoy, start_pc: start, reload_idx: reload_idx,
			count: count, stall_pct: stall_pct};
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic build_table();
		add_row("boot", BOOT_ONLY, '0, frontend_pkg::BOOT_PC, -1, 24, 20);
		add_row("flush_aligned", ONE_FLUSH, '0, 64'h80, -1, 20, 30);
		add_row("flush_high_half", ONE_FLUSH, '0, 64'h10c, -1, 12, 10);
		add_row("backpressure_wrap", ONE_FLUSH, '0, 64'h1c4, -1, 160, 80); // crosses two wraps.
		add_row("double_flush", TWO_FLUSH, 64'h40, 64'h148, -1, 16, 25);
		add_row("reload_word", ONE_FLUSH, '0, 64'h88, 17, 10, 0); // word 17 holds 0x88.
	endtask

	// one load strobe, image kept in step.
	task automatic write_word(input logic [frontend_pkg::MEM_AW-1:0] idx,
		input logic [frontend_pkg::XLEN-1:0] data);
		@(posedge CLK);
		mem_we <= 1'b1;
		mem_waddr <= idx;
		mem_wdata <= data;
		image[idx] = data;
		@(posedge CLK);
		mem_we <= 1'b0;
	endtask

	task automatic load_image();
		for (int i = 0; i < frontend_pkg::MEM_WORDS; i++) begin
			write_word(6'(i), {pattern(9'(i * 8 + 4)), pattern(9'(i * 8))});
		end
	endtask

	// decode held off so nothing transfers in the flush cycle.
	task automatic pulse_flush(input logic [frontend_pkg::XLEN-1:0] target);
		@(posedge CLK);
		flush <= 1'b1;
		redirect_pc <= target;
		dec_ready <= 1'b0;
		@(posedge CLK);
		flush <= 1'b0;
	endtask

	// checks row.count handshakes against the sequential rule.
	task automatic collect(input string name, input row_t row);
		logic [frontend_pkg::XLEN-1:0] exp_pc;
		logic [31:0] exp_instr;
		int got;
		int cycles;
		exp_pc = row.start_pc;
		got = 0;
		cycles = 0;
		while (got < row.count && cycles < row.count * 40 + 200) begin
			@(negedge CLK); // outputs settled, dec_ready set last edge.
			if (dec_valid && dec_ready) begin
				exp_instr = expect_instr(exp_pc);
				if (dec_out.pc !== exp_pc) begin
					mismatches++;
					$display("MISMATCH %s pc: expected %h, actual %h", name, exp_pc, dec_out.pc);
				end
				if (dec_out.instr !== exp_instr) begin
					mismatches++;
					$display("MISMATCH %s instr at %h: expected %h, actual %h",
						name, exp_pc, exp_instr, dec_out.instr);
				end
				exp_pc = exp_pc + 64'd4;
				got++;
			end
			@(posedge CLK);
			dec_ready <= (int'($urandom_range(99, 0)) >= row.stall_pct);
			cycles++;
		end
		if (got < row.count) begin
			timeouts++;
			$display("timeout in %s: decode got only %0d of %0d instructions",
				name, got, row.count);
		end
	endtask

	initial begin
		CLK = 1'b0;
		rst_n = 1'b1;
		mem_we = 1'b0;
		mem_waddr = '0;
		mem_wdata = '0;
		flush = 1'b0;
		redirect_pc = '0;
		dec_ready = 1'b0;
		mismatches = 0;
		timeouts = 0;
		void'($urandom(32'hf98f));
		build_table();
		load_image(); // whole program in place before reset ends.
		@(posedge CLK);
		rst_n <= 1'b0;
		repeat (3) @(posedge CLK);
		rst_n <= 1'b1;
		@(negedge CLK);
		if (dec_valid !== 1'b0) begin
			mismatches++;
			$display("MISMATCH reset dec_valid: expected 0, actual %b", dec_valid);
		end
		for (int r = 0; r < rows.size(); r++) begin
			if (rows[r].reload_idx >= 0) begin
				write_word(6'(rows[r].reload_idx), ~image[6'(rows[r].reload_idx)]);
			end
			if (rows[r].kind == TWO_FLUSH) pulse_flush(rows[r].decoy_pc); // stream must vanish.
			if (rows[r].kind != BOOT_ONLY) pulse_flush(rows[r].start_pc);
			collect(names[r], rows[r]);
		end
		$display("checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
